// ==== design/mips_pkg.sv ====
package mips_pkg;

	//////////////////////////////
	// instruction encodings
	//////////////////////////////

	// primary opcode field, instr[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J = 6'h02, OP_JAL = 6'h03,
		OP_BEQ = 6'h04, OP_BNE = 6'h05, OP_BLEZ = 6'h06, OP_BGTZ = 6'h07,
		OP_ADDI = 6'h08, OP_ADDIU = 6'h09, OP_SLTI = 6'h0a, OP_SLTIU = 6'h0b,
		OP_ANDI = 6'h0c, OP_ORI = 6'h0d, OP_XORI = 6'h0e, OP_LUI = 6'h0f,
		OP_COP0 = 6'h10,
		OP_LB = 6'h20, OP_LH = 6'h21, OP_LW = 6'h23, OP_LBU = 6'h24, OP_LHU = 6'h25,
		OP_SB = 6'h28, OP_SH = 6'h29, OP_SW = 6'h2b
	} opcode_e;

	// funct field of the special group, instr[5:0]
	typedef enum logic [5:0] {
		FN_SLL = 6'h00, FN_SRL = 6'h02, FN_SRA = 6'h03,
		FN_SLLV = 6'h04, FN_SRLV = 6'h06, FN_SRAV = 6'h07,
		FN_MFHI = 6'h10, FN_MTHI = 6'h11, FN_MFLO = 6'h12, FN_MTLO = 6'h13,
		FN_MULT = 6'h18, FN_MULTU = 6'h19, FN_DIV = 6'h1a, FN_DIVU = 6'h1b,
		FN_ADD = 6'h20, FN_ADDU = 6'h21, FN_SUB = 6'h22, FN_SUBU = 6'h23,
		FN_AND = 6'h24, FN_OR = 6'h25, FN_XOR = 6'h26, FN_NOR = 6'h27,
		FN_SLT = 6'h2a, FN_SLTU = 6'h2b
	} funct_e;

	//////////////////////////////
	// datapath selectors
	//////////////////////////////

	// alu operation, decoder to alu
	typedef enum logic [3:0] {
		ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_e;

	// multiply/divide operation, decoder to mult_div
	typedef enum logic [2:0] {
		MD_NONE, MD_MULT, MD_MULTU, MD_DIV, MD_DIVU
	} md_op_e;

	// execution sequence
	typedef enum logic [2:0] {
		S_IDLE, S_DECODE, S_EXECUTE, S_MD_RUN, S_WRITEBACK
	} exec_state_e;

	//////////////////////////////
	// apb register map
	//////////////////////////////

	localparam logic [7:0] ADDR_INSTR    = 8'h00;  // write only
	localparam logic [7:0] ADDR_REG_SEL  = 8'h04;
	localparam logic [7:0] ADDR_REG_DATA = 8'h08;
	localparam logic [7:0] ADDR_RETIRED  = 8'h0c;
	localparam logic [7:0] ADDR_HI       = 8'h10;
	localparam logic [7:0] ADDR_LO       = 8'h14;
	// bit 0 sticky invalid, any write clears
	localparam logic [7:0] ADDR_STATUS   = 8'h18;

endpackage

// ==== design/main_decoder.sv ====
`timescale 1ns/100ps
module main_decoder (
	input  logic [5:0] op,
	input  logic [4:0] rs,
	input  logic [4:0] rt,
	input  logic [5:0] funct,
	output logic regwrite,
	output logic regdst,
	output logic alusrc,
	output logic hilowrite,
	output logic sign_ext,
	output mips_pkg::alu_op_e alu_op,
	output mips_pkg::md_op_e md_op,
	output logic rd_hi,
	output logic rd_lo,
	output logic invalid
);
	import mips_pkg::*;

	// control word {regwrite, regdst, alusrc, hilowrite, sign_ext}
	localparam logic [4:0] C_NONE  = 5'b00000;
	localparam logic [4:0] C_RTYPE = 5'b11000;
	localparam logic [4:0] C_IMM_Z = 5'b10100;
	localparam logic [4:0] C_IMM_S = 5'b10101;
	localparam logic [4:0] C_HILO  = 5'b00010;

	logic [4:0] ctrl;
	logic reject;
	alu_op_e r_alu;
	alu_op_e i_alu;

	assign {regwrite, regdst, alusrc, hilowrite, sign_ext} = ctrl;

	// special group alu op, by funct
	always_comb begin
		case (funct)
			FN_AND:          r_alu = ALU_AND;
			FN_OR:           r_alu = ALU_OR;
			FN_XOR:          r_alu = ALU_XOR;
			FN_NOR:          r_alu = ALU_NOR;
			FN_SLL, FN_SLLV: r_alu = ALU_SLL;
			FN_SRL, FN_SRLV: r_alu = ALU_SRL;
			FN_SRA, FN_SRAV: r_alu = ALU_SRA;
			FN_SUB, FN_SUBU: r_alu = ALU_SUB;
			FN_SLT:          r_alu = ALU_SLT;
			FN_SLTU:         r_alu = ALU_SLTU;
			default:         r_alu = ALU_ADD;
		endcase
	end

	// immediate group alu op, by opcode
	always_comb begin
		case (op)
			OP_ANDI:  i_alu = ALU_AND;
			OP_ORI:   i_alu = ALU_OR;
			OP_XORI:  i_alu = ALU_XOR;
			OP_LUI:   i_alu = ALU_LUI;
			OP_SLTI:  i_alu = ALU_SLT;
			OP_SLTIU: i_alu = ALU_SLTU;
			default:  i_alu = ALU_ADD;
		endcase
	end

	always_comb begin
		ctrl = C_NONE;
		alu_op = ALU_ADD;
		md_op = MD_NONE;
		rd_hi = 1'b0;
		rd_lo = 1'b0;
		reject = 1'b0;
		case (op)
			OP_SPECIAL: begin
				alu_op = r_alu;
				case (funct)
					// logic, shift, arithmetic into rd
					FN_AND, FN_OR, FN_XOR, FN_NOR,
					FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
					FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU: ctrl = C_RTYPE;
					// hi/lo results, no gpr write
					FN_MULT:  md_op = MD_MULT;
					FN_MULTU: md_op = MD_MULTU;
					FN_DIV:   md_op = MD_DIV;
					FN_DIVU:  md_op = MD_DIVU;
					FN_MFHI, FN_MFLO: begin
						ctrl = C_RTYPE;
						rd_hi = (funct == FN_MFHI);
						rd_lo = (funct == FN_MFLO);
						// rs and rt are reserved zero
						reject = (rs != 5'd0) || (rt != 5'd0);
					end
					FN_MTHI, FN_MTLO: begin
						ctrl = C_HILO;
						reject = (rt != 5'd0);
					end
					// syscall, break, jr, jalr, unknown
					default: reject = 1'b1;
				endcase
			end
			OP_ANDI, OP_ORI, OP_XORI: begin
				ctrl = C_IMM_Z;
				alu_op = i_alu;
			end
			OP_LUI: begin
				ctrl = C_IMM_Z;
				alu_op = i_alu;
				reject = (rs != 5'd0);
			end
			// sltiu compares unsigned but still sign-extends
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				ctrl = C_IMM_S;
				alu_op = i_alu;
			end
			// branches, jumps, loads, stores, cop0, unknown
			default: reject = 1'b1;
		endcase
		// rejected words retire with no side effect
		if (reject) begin
			ctrl = C_NONE;
			md_op = MD_NONE;
			rd_hi = 1'b0;
			rd_lo = 1'b0;
		end
		invalid = reject;
	end

endmodule

// ==== design/alu.sv ====
`timescale 1ns/100ps
module alu #(
	parameter int DATA_W = 32
) (
	input  mips_pkg::alu_op_e alu_op,
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	input  logic [4:0] shamt,
	output logic [DATA_W-1:0] result
);
	import mips_pkg::*;

	localparam int HALF = DATA_W / 2;

	logic lt_s;
	logic lt_u;

	// compares for slt / sltu
	assign lt_s = $signed(a) < $signed(b);
	assign lt_u = a < b;

	always_comb begin
		case (alu_op)
			ALU_AND:  result = a & b;
			ALU_OR:   result = a | b;
			ALU_XOR:  result = a ^ b;
			ALU_NOR:  result = ~(a | b);
			// add/sub wrap, no overflow trap
			ALU_ADD:  result = a + b;
			ALU_SUB:  result = a - b;
			ALU_SLT:  result = {{(DATA_W-1){1'b0}}, lt_s};
			ALU_SLTU: result = {{(DATA_W-1){1'b0}}, lt_u};
			// shifts act on b (rt)
			ALU_SLL:  result = b << shamt;
			ALU_SRL:  result = b >> shamt;
			ALU_SRA:  result = $signed(b) >>> shamt;
			// immediate into upper half
			ALU_LUI:  result = {b[HALF-1:0], {HALF{1'b0}}};
			default:  result = a + b;
		endcase
	end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/100ps
module reg_file #(
	parameter int DATA_W = 32
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [4:0] ra1,
	input  logic [4:0] ra2,
	input  logic we,
	input  logic [4:0] wa,
	input  logic [DATA_W-1:0] wd,
	input  logic hilo_we,
	input  logic [DATA_W-1:0] hi_wd,
	input  logic [DATA_W-1:0] lo_wd,
	input  logic hi_we_only,
	input  logic lo_we_only,
	output logic [DATA_W-1:0] rd1,
	output logic [DATA_W-1:0] rd2,
	output logic [DATA_W-1:0] hi,
	output logic [DATA_W-1:0] lo
);

	logic [DATA_W-1:0] regs [32];

	// general registers, r0 never written so reads zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && (wa != 5'd0)) begin
			regs[wa] <= wd;
		end
	end

	// read ports follow the address
	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

	// hi/lo, both from mult/div, one at a time from mthi/mtlo
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hi <= '0;
			lo <= '0;
		end else begin
			if (hilo_we || hi_we_only)
				hi <= hi_wd;
			if (hilo_we || lo_we_only)
				lo <= lo_wd;
		end
	end

endmodule

// ==== design/mult_div.sv ====
`timescale 1ns/100ps
module mult_div #(
	parameter int DATA_W = 32
) (
	input  logic clk,
	input  logic rst_n,
	input  mips_pkg::md_op_e md_op,
	input  logic start,
	input  logic step,
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	output logic [DATA_W-1:0] md_hi,
	output logic [DATA_W-1:0] md_lo
);
	import mips_pkg::*;

	logic signed_op;
	logic a_neg, b_neg;
	logic [DATA_W-1:0] a_mag, b_mag;
	// latched op and result signs
	logic is_div, prod_neg, rem_neg, quo_neg;
	// hi_r: partial product / remainder, lo_r: multiplier / quotient
	logic [DATA_W-1:0] hi_r, lo_r, opd_b;
	logic [DATA_W:0] mul_sum;
	logic [DATA_W:0] div_shift, div_diff;
	logic [2*DATA_W-1:0] prod, prod_fix;

	assign signed_op = (md_op == MD_MULT) || (md_op == MD_DIV);
	assign a_neg = signed_op & a[DATA_W-1];
	assign b_neg = signed_op & b[DATA_W-1];
	assign a_mag = a_neg ? -a : a;
	assign b_mag = b_neg ? -b : b;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			is_div <= 1'b0;
			prod_neg <= 1'b0;
			rem_neg <= 1'b0;
			quo_neg <= 1'b0;
		end else if (start) begin
			is_div <= (md_op == MD_DIV) || (md_op == MD_DIVU);
			prod_neg <= a_neg ^ b_neg;
			// remainder takes the dividend sign
			rem_neg <= a_neg;
			// divide by zero keeps lo all ones
			quo_neg <= (a_neg ^ b_neg) && (b != '0);
		end
	end

	// one shift-add bit
	assign mul_sum = {1'b0, hi_r} + (lo_r[0] ? {1'b0, opd_b} : '0);
	// one restoring divide bit
	assign div_shift = {hi_r, lo_r[DATA_W-1]};
	assign div_diff = div_shift - {1'b0, opd_b};

	always_ff @(posedge clk) begin
		if (start) begin
			hi_r <= '0;
			lo_r <= a_mag;
			opd_b <= b_mag;
		end else if (step) begin
			if (is_div) begin
				if (div_shift >= {1'b0, opd_b}) begin
					hi_r <= div_diff[DATA_W-1:0];
					lo_r <= {lo_r[DATA_W-2:0], 1'b1};
				end else begin
					hi_r <= div_shift[DATA_W-1:0];
					lo_r <= {lo_r[DATA_W-2:0], 1'b0};
				end
			end else begin
				hi_r <= mul_sum[DATA_W:1];
				lo_r <= {mul_sum[0], lo_r[DATA_W-1:1]};
			end
		end
	end

	// sign fix-up on the way out
	assign prod = {hi_r, lo_r};
	assign prod_fix = prod_neg ? -prod : prod;
	assign md_hi = is_div ? (rem_neg ? -hi_r : hi_r) : prod_fix[2*DATA_W-1:DATA_W];
	assign md_lo = is_div ? (quo_neg ? -lo_r : lo_r) : prod_fix[DATA_W-1:0];

endmodule

// ==== design/iter_counter.sv ====
`timescale 1ns/100ps
module iter_counter #(
	parameter int MD_STEPS = 32,
	parameter int CNT_W = 16
) (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic retire,
	output logic step,
	output logic done,
	output logic [CNT_W-1:0] retired
);

	localparam int STEP_W = $clog2(MD_STEPS + 1);

	logic [STEP_W-1:0] steps_left;

	// mult/div pacing, loaded on start
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			steps_left <= '0;
		else if (start)
			steps_left <= STEP_W'(MD_STEPS);
		else if (steps_left != '0)
			steps_left <= steps_left - 1'b1;
	end

	assign step = (steps_left != '0);
	// high in the last step cycle
	assign done = (steps_left == STEP_W'(1));

	// retired instructions, wraps
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			retired <= '0;
		else if (retire)
			retired <= retired + 1'b1;
	end

endmodule

// ==== design/exec_fsm.sv ====
`timescale 1ns/100ps
module exec_fsm #(
	parameter int DATA_W = 32,
	parameter int CNT_W = 16
) (
	input  logic clk,
	input  logic rst_n,
	// apb slave
	input  logic [7:0] paddr,
	input  logic psel, penable, pwrite,
	input  logic [DATA_W-1:0] pwdata,
	output logic [DATA_W-1:0] prdata,
	output logic pready, pslverr,
	// decoder
	output logic [5:0] op,
	output logic [4:0] rs, rt,
	output logic [5:0] funct,
	input  logic regwrite, regdst, alusrc, hilowrite, sign_ext,
	input  mips_pkg::md_op_e md_op,
	input  logic rd_hi, rd_lo, invalid,
	// register file
	output logic [4:0] ra1, ra2, wa,
	output logic we, hilo_we, hi_we_only, lo_we_only,
	output logic [DATA_W-1:0] wd, hi_wd, lo_wd,
	input  logic [DATA_W-1:0] rs_data, rt_data, hi, lo,
	// alu
	output logic [DATA_W-1:0] alu_a, alu_b,
	output logic [4:0] alu_shamt,
	input  logic [DATA_W-1:0] alu_result,
	// mult/div and counters
	output logic md_start, retire,
	input  logic md_done,
	input  logic [DATA_W-1:0] md_hi, md_lo,
	input  logic [CNT_W-1:0] retired
);
	import mips_pkg::*;

	exec_state_e state, state_next;
	logic [31:0] instr;
	logic [DATA_W-1:0] opd_a, opd_b, result, imm_ext, rdata;
	logic [4:0] reg_sel;
	logic inv_flag;
	logic access, idle, idle_wr, instr_wr, in_wb, mapped;

	assign access = psel & penable;
	assign idle = (state == S_IDLE);
	assign idle_wr = access & pwrite & idle;
	assign instr_wr = idle_wr & (paddr == ADDR_INSTR);
	assign in_wb = (state == S_WRITEBACK);

	// fields of the held instruction
	assign op = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign funct = instr[5:0];

	//////////////////////////////
	// sequence
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= S_IDLE;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			S_IDLE:      if (instr_wr) state_next = S_DECODE;
			S_DECODE:    state_next = S_EXECUTE;
			S_EXECUTE:   state_next = (md_op != MD_NONE) ? S_MD_RUN : S_WRITEBACK;
			S_MD_RUN:    if (md_done) state_next = S_WRITEBACK;
			S_WRITEBACK: state_next = S_IDLE;
			default:     state_next = S_IDLE;
		endcase
	end

	// instruction, operands, result
	always_ff @(posedge clk) begin
		if (instr_wr)
			instr <= pwdata[31:0];
		if (state == S_DECODE) begin
			opd_a <= rs_data;
			opd_b <= rt_data;
		end
		// write-back source alu, hi or lo
		if (state == S_EXECUTE)
			result <= rd_hi ? hi : (rd_lo ? lo : alu_result);
	end

	// host select and sticky invalid
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reg_sel <= '0;
			inv_flag <= 1'b0;
		end else begin
			if (idle_wr && (paddr == ADDR_REG_SEL))
				reg_sel <= pwdata[4:0];
			if (in_wb && invalid)
				inv_flag <= 1'b1;
			else if (idle_wr && (paddr == ADDR_STATUS))
				inv_flag <= 1'b0;
		end
	end

	//////////////////////////////
	// datapath steering
	//////////////////////////////

	assign imm_ext = sign_ext ? {{(DATA_W-16){instr[15]}}, instr[15:0]}
	                          : {{(DATA_W-16){1'b0}}, instr[15:0]};
	assign alu_a = opd_a;
	assign alu_b = alusrc ? imm_ext : opd_b;
	// variable shifts take the amount from rs
	assign alu_shamt = (funct inside {FN_SLLV, FN_SRLV, FN_SRAV}) ? opd_a[4:0] : instr[10:6];

	// port 1 serves the host while idle
	assign ra1 = idle ? reg_sel : rs;
	assign ra2 = rt;
	assign we = in_wb ? regwrite : (idle_wr && (paddr == ADDR_REG_DATA));
	assign wa = in_wb ? (regdst ? instr[15:11] : rt) : reg_sel;
	assign wd = in_wb ? result : pwdata;

	assign hilo_we = in_wb && (md_op != MD_NONE);
	assign hi_we_only = in_wb && hilowrite && (funct == FN_MTHI);
	assign lo_we_only = in_wb && hilowrite && (funct == FN_MTLO);
	assign hi_wd = hilo_we ? md_hi : opd_a;
	assign lo_wd = hilo_we ? md_lo : opd_a;

	assign md_start = (state == S_EXECUTE) && (md_op != MD_NONE);
	assign retire = in_wb;

	//////////////////////////////
	// apb response
	//////////////////////////////

	// instruction writes wait for writeback
	assign pready = access & ((idle & ~instr_wr) | in_wb);
	assign mapped = paddr inside {ADDR_INSTR, ADDR_REG_SEL, ADDR_REG_DATA, ADDR_RETIRED,
	                              ADDR_HI, ADDR_LO, ADDR_STATUS};
	assign pslverr = pready & ~mapped;

	always_comb begin
		case (paddr)
			ADDR_REG_SEL:  rdata = {{(DATA_W-5){1'b0}}, reg_sel};
			ADDR_REG_DATA: rdata = rs_data;
			ADDR_RETIRED:  rdata = {{(DATA_W-CNT_W){1'b0}}, retired};
			ADDR_HI:       rdata = hi;
			ADDR_LO:       rdata = lo;
			ADDR_STATUS:   rdata = {{(DATA_W-1){1'b0}}, inv_flag};
			default:       rdata = '0;
		endcase
	end

	assign prdata = (pready && !pwrite) ? rdata : '0;

endmodule

// ==== design/mips_exec_top.sv ====
`timescale 1ns/100ps
module mips_exec_top #(
	parameter int DATA_W = 32,
	parameter int CNT_W = 16
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [7:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [DATA_W-1:0] pwdata,
	output logic [DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	import mips_pkg::*;

	// decoder
	logic [5:0] op, funct;
	logic [4:0] rs, rt;
	logic regwrite, regdst, alusrc, hilowrite, sign_ext, rd_hi, rd_lo, invalid;
	alu_op_e alu_op;
	md_op_e md_op;
	// register file
	logic [4:0] ra1, ra2, wa;
	logic we, hilo_we, hi_we_only, lo_we_only;
	logic [DATA_W-1:0] wd, hi_wd, lo_wd, rs_data, rt_data, hi, lo;
	// alu, mult/div, counters
	logic [DATA_W-1:0] alu_a, alu_b, alu_result, md_hi, md_lo;
	logic [4:0] alu_shamt;
	logic md_start, md_step, md_done, retire;
	logic [CNT_W-1:0] retired;

	main_decoder u_decoder (
		.op(op), .rs(rs), .rt(rt), .funct(funct),
		.regwrite(regwrite), .regdst(regdst), .alusrc(alusrc),
		.hilowrite(hilowrite), .sign_ext(sign_ext), .alu_op(alu_op), .md_op(md_op),
		.rd_hi(rd_hi), .rd_lo(rd_lo), .invalid(invalid)
	);

	alu #(.DATA_W(DATA_W)) u_alu (
		.alu_op(alu_op), .a(alu_a), .b(alu_b), .shamt(alu_shamt), .result(alu_result)
	);

	reg_file #(.DATA_W(DATA_W)) u_reg_file (
		.clk(clk), .rst_n(rst_n), .ra1(ra1), .ra2(ra2),
		.we(we), .wa(wa), .wd(wd),
		.hilo_we(hilo_we), .hi_wd(hi_wd), .lo_wd(lo_wd),
		.hi_we_only(hi_we_only), .lo_we_only(lo_we_only),
		.rd1(rs_data), .rd2(rt_data), .hi(hi), .lo(lo)
	);

	// operands shared with the alu
	mult_div #(.DATA_W(DATA_W)) u_mult_div (
		.clk(clk), .rst_n(rst_n), .md_op(md_op), .start(md_start), .step(md_step),
		.a(alu_a), .b(alu_b), .md_hi(md_hi), .md_lo(md_lo)
	);

	iter_counter #(.MD_STEPS(DATA_W), .CNT_W(CNT_W)) u_iter_counter (
		.clk(clk), .rst_n(rst_n), .start(md_start), .retire(retire),
		.step(md_step), .done(md_done), .retired(retired)
	);

	exec_fsm #(.DATA_W(DATA_W), .CNT_W(CNT_W)) u_exec_fsm (
		.clk(clk), .rst_n(rst_n),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.op(op), .rs(rs), .rt(rt), .funct(funct),
		.regwrite(regwrite), .regdst(regdst), .alusrc(alusrc),
		.hilowrite(hilowrite), .sign_ext(sign_ext), .md_op(md_op),
		.rd_hi(rd_hi), .rd_lo(rd_lo), .invalid(invalid),
		.ra1(ra1), .ra2(ra2), .wa(wa), .we(we),
		.hilo_we(hilo_we), .hi_we_only(hi_we_only), .lo_we_only(lo_we_only),
		.wd(wd), .hi_wd(hi_wd), .lo_wd(lo_wd),
		.rs_data(rs_data), .rt_data(rt_data), .hi(hi), .lo(lo),
		.alu_a(alu_a), .alu_b(alu_b), .alu_shamt(alu_shamt), .alu_result(alu_result),
		.md_start(md_start), .retire(retire), .md_done(md_done),
		.md_hi(md_hi), .md_lo(md_lo), .retired(retired)
	);

endmodule

// ==== sim/tb_mips_exec.sv ====
`timescale 1ns/100ps
module tb_mips_exec;
	import mips_pkg::*;

	localparam int DATA_W = 32;
	localparam int CNT_W = 16;
	localparam int MAX_TESTS = 64;
	localparam int CYCLES_PER_TEST = 50;

	// columns of one stimulus row
	localparam int C_RS_IDX = 0;
	localparam int C_RS_VAL = 1;
	localparam int C_RT_IDX = 2;
	localparam int C_RT_VAL = 3;
	localparam int C_INSTR = 4;
	localparam int C_DST_IDX = 5;
	localparam int C_DST_VAL = 6;
	localparam int C_HI = 7;
	localparam int C_LO = 8;
	localparam int C_INV = 9;

	logic clk;
	logic rst_n;
	logic [7:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [DATA_W-1:0] pwdata;
	logic [DATA_W-1:0] prdata;
	logic pready;
	logic pslverr;

	logic [31:0] tests [MAX_TESTS][10];
	int num_tests = 0;
	int errors = 0;
	int checks = 0;
	int instr_count = 0;
	int cycles = 0;
	int cycle_limit = 0;

	mips_exec_top #(.DATA_W(DATA_W), .CNT_W(CNT_W)) uut (
		.clk(clk), .rst_n(rst_n),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// run limit armed once the test count is known
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	//////////////////////////////
	// apb master
	//////////////////////////////

	// setup then access cycles until pready
	// bus stays in access for a back-to-back follow-up
	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
			output logic [31:0] rdata, output logic err, output int n_access);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		// sample mid-cycle once pready has settled
		n_access = 1;
		@(negedge clk);
		while (!pready) begin
			@(negedge clk);
			n_access++;
		end
		rdata = prdata;
		err = pslverr;
	endtask

	task automatic apb_idle;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rdata_unused;
		logic err;
		int n_access;
		apb_xfer(1'b1, addr, data, rdata_unused, err, n_access);
		compare($sformatf("pslverr (write 0x%h)", addr), {31'b0, err}, 32'h0);
		compare($sformatf("pready access cycles (write 0x%h)", addr), n_access, 1);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		logic err;
		int n_access;
		apb_xfer(1'b0, addr, 32'h0, data, err, n_access);
		compare($sformatf("pslverr (read 0x%h)", addr), {31'b0, err}, 32'h0);
		compare($sformatf("pready access cycles (read 0x%h)", addr), n_access, 1);
	endtask

	// pready stays low through decode, execute, md_run and writeback
	task automatic issue_instr(input int t, input logic [31:0] instr);
		logic [31:0] rdata_unused;
		logic err;
		int n_access;
		int exp_access;
		// ready in the fourth access cycle
		exp_access = 4;
		// each multiply or divide step adds one cycle
		if (instr[31:26] == OP_SPECIAL &&
				instr[5:0] inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU})
			exp_access = 4 + DATA_W;
		apb_xfer(1'b1, ADDR_INSTR, instr, rdata_unused, err, n_access);
		compare($sformatf("pslverr (test %0d)", t), {31'b0, err}, 32'h0);
		compare($sformatf("pready access cycles (test %0d)", t), n_access, exp_access);
	endtask

	// gpr access goes through the select register
	task automatic write_reg(input logic [4:0] idx, input logic [31:0] val);
		apb_write(ADDR_REG_SEL, {27'b0, idx});
		apb_write(ADDR_REG_DATA, val);
	endtask

	task automatic expect_reg(input int t, input logic [4:0] idx, input logic [31:0] exp);
		logic [31:0] val;
		apb_write(ADDR_REG_SEL, {27'b0, idx});
		apb_read(ADDR_REG_DATA, val);
		compare($sformatf("r%0d (test %0d)", idx, t), val, exp);
	endtask

	task automatic expect_csr(input string name, input logic [7:0] addr, input logic [31:0] exp);
		logic [31:0] val;
		apb_read(addr, val);
		compare(name, val, exp);
	endtask

	//////////////////////////////
	// stimulus file
	//////////////////////////////

	task automatic load_tests;
		int fd;
		int n;
		string line;
		fd = $fopen("sim/exec_stimulus.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd) && num_tests < MAX_TESTS) begin
				n = $fgets(line, fd);
				if (n > 0) begin
					// comment and blank lines do not parse
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
						tests[num_tests][0], tests[num_tests][1], tests[num_tests][2],
						tests[num_tests][3], tests[num_tests][4], tests[num_tests][5],
						tests[num_tests][6], tests[num_tests][7], tests[num_tests][8],
						tests[num_tests][9]);
					if (n == 10)
						num_tests++;
				end
			end
			$fclose(fd);
		end
	endtask

	// one instruction with preload, issue and full read-back
	task automatic run_test(input int t);
		logic [4:0] rs_i;
		logic [4:0] rt_i;
		logic [4:0] dst_i;
		logic [31:0] val;
		rs_i = tests[t][C_RS_IDX][4:0];
		rt_i = tests[t][C_RT_IDX][4:0];
		dst_i = tests[t][C_DST_IDX][4:0];
		if (rs_i != 5'd0)
			write_reg(rs_i, tests[t][C_RS_VAL]);
		if (rt_i != 5'd0)
			write_reg(rt_i, tests[t][C_RT_VAL]);
		issue_instr(t, tests[t][C_INSTR]);
		instr_count++;
		expect_reg(t, dst_i, tests[t][C_DST_VAL]);
		expect_csr($sformatf("hi (test %0d)", t), ADDR_HI, tests[t][C_HI]);
		expect_csr($sformatf("lo (test %0d)", t), ADDR_LO, tests[t][C_LO]);
		apb_read(ADDR_STATUS, val);
		compare($sformatf("status (test %0d)", t), val, tests[t][C_INV]);
		// any write clears the sticky bit
		if (tests[t][C_INV][0]) begin
			apb_write(ADDR_STATUS, 32'h0);
			expect_csr($sformatf("status cleared (test %0d)", t), ADDR_STATUS, 32'h0);
		end
		// sources untouched unless also the destination
		if (rs_i != dst_i)
			expect_reg(t, rs_i, tests[t][C_RS_VAL]);
		if (rt_i != dst_i)
			expect_reg(t, rt_i, tests[t][C_RT_VAL]);
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		logic [31:0] rdata;
		logic err;
		int n_access;
		rst_n <= 1'b0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= 8'h00;
		pwdata <= '0;
		load_tests();
		if (num_tests == 0) begin
			$display("no test rows could be read from sim/exec_stimulus.txt");
			$display("Simulation failed");
			$finish;
		end else begin
			cycle_limit = num_tests * CYCLES_PER_TEST + 200;
			repeat (3) @(posedge clk);
			rst_n <= 1'b1;
			// everything starts at zero
			expect_csr("retired after reset", ADDR_RETIRED, 32'h0);
			expect_csr("hi after reset", ADDR_HI, 32'h0);
			expect_csr("lo after reset", ADDR_LO, 32'h0);
			expect_csr("status after reset", ADDR_STATUS, 32'h0);
			expect_reg(-1, 5'd0, 32'h0);
			expect_reg(-1, 5'd1, 32'h0);
			expect_reg(-1, 5'd17, 32'h0);
			expect_reg(-1, 5'd31, 32'h0);
			for (int t = 0; t < num_tests; t++)
				run_test(t);
			// unmapped offsets answer with pslverr
			apb_xfer(1'b0, 8'h1c, 32'h0, rdata, err, n_access);
			compare("pslverr (read 0x1c)", {31'b0, err}, 32'h1);
			compare("pready access cycles (read 0x1c)", n_access, 1);
			apb_xfer(1'b1, 8'h40, 32'h1234_5678, rdata, err, n_access);
			compare("pslverr (write 0x40)", {31'b0, err}, 32'h1);
			compare("pready access cycles (write 0x40)", n_access, 1);
			// invalid words retire too
			expect_csr("retired", ADDR_RETIRED, 32'(instr_count));
			apb_idle();
			$display("%0d tests, %0d checks, %0d errors", num_tests, checks, errors);
			if (errors == 0)
				$display("Simulation passed");
			else
				$display("Simulation failed");
			$finish;
		end
	end

endmodule

// ==== sim/exec_stimulus.txt ====
# rs_idx rs_val rt_idx rt_val instr dst_idx dst_val hi lo invalid, all hex
# registers rs/rt are preloaded, dst/hi/lo/status are read back after the instruction
01 f0f01234 02 0ff0ff00 00221824 03 00f01200 00000000 00000000 0
01 a5a50000 02 00005a5a 00222025 04 a5a55a5a 00000000 00000000 0
06 ffff0000 07 0f0f0f0f 00c72826 05 f0f00f0f 00000000 00000000 0
06 12340000 07 00005678 00c74027 08 edcba987 00000000 00000000 0
00 00000000 07 800000f1 00074900 09 00000f10 00000000 00000000 0
00 00000000 07 87654321 00075203 0a ff876543 00000000 00000000 0
06 00000024 07 f0000000 00c75806 0b 0f000000 00000000 00000000 0
01 7fffffff 02 00000001 00226020 0c 80000000 00000000 00000000 0
01 00000005 02 00000007 00226822 0d fffffffe 00000000 00000000 0
01 ffffffff 02 00000001 0022702a 0e 00000001 00000000 00000000 0
02 00000001 01 ffffffff 0041782b 0f 00000001 00000000 00000000 0
01 00000010 00 00000000 2030fffd 10 0000000d 00000000 00000000 0
01 fffffffe 00 00000000 2831ffff 11 00000001 00000000 00000000 0
01 ffffffff 00 00000000 30328f0f 12 00008f0f 00000000 00000000 0
01 12340000 00 00000000 34338000 13 12348000 00000000 00000000 0
01 ffff1234 00 00000000 3834ffff 14 ffffedcb 00000000 00000000 0
00 00000000 00 00000000 3c15beef 15 beef0000 00000000 00000000 0
01 fffffffd 02 00000005 00220018 00 00000000 ffffffff fffffff1 0
01 ffffffff 02 00000002 00220019 00 00000000 00000001 fffffffe 0
01 fffffff9 02 00000002 0022001a 00 00000000 ffffffff fffffffd 0
01 00000064 02 00000007 0022001b 00 00000000 00000002 0000000e 0
01 ffffff00 02 00000000 0022001a 00 00000000 ffffff00 ffffffff 0
00 00000000 00 00000000 0000b010 16 ffffff00 ffffff00 ffffffff 0
00 00000000 00 00000000 0000b812 17 ffffffff ffffff00 ffffffff 0
01 cafe0001 00 00000000 00200011 00 00000000 cafe0001 ffffffff 0
02 0badf00d 00 00000000 00400013 00 00000000 cafe0001 0badf00d 0
01 00000001 00 00000000 20200005 00 00000000 cafe0001 0badf00d 0
01 00000003 02 00000004 10220004 03 00f01200 cafe0001 0badf00d 1
01 00000008 00 00000000 8c250000 05 f0f00f0f cafe0001 0badf00d 1
01 00000009 02 0000000a fc221234 04 a5a55a5a cafe0001 0badf00d 1

// ==== list.f ====
design/mips_pkg.sv
design/main_decoder.sv
design/alu.sv
design/reg_file.sv
design/mult_div.sv
design/iter_counter.sv
design/exec_fsm.sv
design/mips_exec_top.sv
sim/tb_mips_exec.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_mips_exec -f list.f
out=$(./obj_dir/Vtb_mips_exec)
echo "$out"
echo "$out" | grep -qx "Simulation passed"
